// ==== cp_s1_top.f ====
source/cp_mem_pkg.sv
source/cp_ctrl_pkg.sv
source/cp_sample_ram.sv
source/cp_sample_writer.sv
source/cp_read_arbiter.sv
source/cp_burst_reader.sv
source/cp_s1_top.sv
tb/cp_s1_asserts.sv
tb/cp_s1_checker.sv
tb/cp_s1_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stage one capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module cp_s1_tb -f cp_s1_top.f -o cp_s1_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/cp_s1_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== tb/cp_s1_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_s1_tb
  import cp_mem_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 400;

  logic    clk;
  logic    rst_n;
  sample_t i_sample;
  logic    i_sample_vld;
  logic    i_start0;
  logic    i_start1;
  word_t   o_data0;
  logic    o_valid0;
  logic    o_last0;
  word_t   o_data1;
  logic    o_valid1;
  logic    o_last1;
  int      check_errors;
  int      timeouts;

  // Shadow copy of the sample RAM
  word_t shadow [RAM_DEPTH];
  word_t pack_word;
  int    pack_lane;
  int    wr_ptr;

  cp_s1_top cp_s1_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_sample     (i_sample),
    .i_sample_vld (i_sample_vld),
    .i_start0     (i_start0),
    .i_start1     (i_start1),
    .o_data0      (o_data0),
    .o_valid0     (o_valid0),
    .o_last0      (o_last0),
    .o_data1      (o_data1),
    .o_valid1     (o_valid1),
    .o_last1      (o_last1)
  );

  cp_s1_checker checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_data0  (o_data0),
    .i_valid0 (o_valid0),
    .i_last0  (o_last0),
    .i_data1  (o_data1),
    .i_valid1 (o_valid1),
    .i_last1  (o_last1),
    .o_errors (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////////////////////////////////

  // Sample 0 of a group lands in the low 32 bits of the word
  task automatic store_sample(input sample_t s);
    pack_word[pack_lane*SAMPLE_W +: SAMPLE_W] = s;
    pack_lane++;
    if (pack_lane == SAMPLES_PER_WORD) begin
      shadow[wr_ptr] = pack_word;
      wr_ptr = (wr_ptr + 1) % RAM_DEPTH;
      pack_lane = 0;
    end
  endtask

  task automatic write_samples(input int count);
    sample_t s;
    int      gap;
    for (int i = 0; i < count; i++) begin
      gap = $urandom_range(3, 0);
      repeat (gap) begin
        @(posedge clk);
        i_sample_vld <= 1'b0;
      end
      s = $urandom;
      @(posedge clk);
      i_sample     <= s;
      i_sample_vld <= 1'b1;
      store_sample(s);
    end
    @(posedge clk);
    i_sample_vld <= 1'b0;
    // Last word is written two edges after its fourth strobe
    repeat (3) @(posedge clk);
  endtask

  task automatic expect_burst(input int k);
    int base;
    int step;
    int addr;
    base = (k == 0) ? int'(RD_BASE0) : int'(RD_BASE1);
    step = (k == 0) ? int'(RD_STEP0) : int'(RD_STEP1);
    for (int n = 0; n < BURST_LEN; n++) begin
      addr = (base + n * step) % RAM_DEPTH;
      checker_i.expect_word(k, shadow[addr]);
    end
  endtask

  task automatic pulse_start(input bit s0, input bit s1);
    @(posedge clk);
    if (s0) begin
      i_start0 <= 1'b0;
    end
    if (s1) begin
      i_start1 <= 1'b0;
    end
    repeat (4) @(posedge clk);
    i_start0 <= 1'b1;
    i_start1 <= 1'b1;
  endtask

  task automatic wait_bursts(input bit want0, input bit want1);
    bit seen0;
    bit seen1;
    int cycles;
    seen0  = !want0;
    seen1  = !want1;
    cycles = 0;
    while (!(seen0 && seen1) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      seen0 = seen0 || o_last0;
      seen1 = seen1 || o_last1;
      cycles++;
    end
    if (!(seen0 && seen1)) begin
      $display("Timeout: burst end not seen within %0d cycles", TIMEOUT_CYCLES);
      timeouts++;
    end
  endtask

  task automatic wait_first_valid0();
    int cycles;
    cycles = 0;
    while (!o_valid0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_valid0) begin
      $display("Timeout: reader0 returned no word within %0d cycles", TIMEOUT_CYCLES);
      timeouts++;
    end
  endtask

  task automatic end_test();
    repeat (40) @(posedge clk);
    checker_i.check_drained();
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int seed;
    seed = 39;
    void'($urandom(seed));
    rst_n        = 1'b0;
    i_sample     = '0;
    i_sample_vld = 1'b0;
    i_start0     = 1'b1;
    i_start1     = 1'b1;
    pack_word    = '0;
    pack_lane    = 0;
    wr_ptr       = 0;
    timeouts     = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    checker_i.set_test("packing");
    write_samples(256);
    expect_burst(0);
    pulse_start(1'b1, 1'b0);
    wait_bursts(1'b1, 1'b0);
    end_test();

    checker_i.set_test("stride");
    expect_burst(1);
    pulse_start(1'b0, 1'b1);
    wait_bursts(1'b0, 1'b1);
    end_test();

    checker_i.set_test("contention");
    expect_burst(0);
    expect_burst(1);
    pulse_start(1'b1, 1'b1);
    wait_bursts(1'b1, 1'b1);
    end_test();

    // Second fall arrives while the first burst still runs
    checker_i.set_test("restart");
    expect_burst(0);
    pulse_start(1'b1, 1'b0);
    wait_first_valid0();
    pulse_start(1'b1, 1'b0);
    wait_bursts(1'b1, 1'b0);
    end_test();

    // 72 words, so the write address wraps past the top
    checker_i.set_test("refill");
    write_samples(288);
    expect_burst(1);
    expect_burst(0);
    pulse_start(1'b1, 1'b1);
    wait_bursts(1'b1, 1'b1);
    end_test();

    $display("Closing: %0d check errors, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/cp_s1_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_s1_checker
  import cp_mem_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  word_t i_data0,
  input  wire   i_valid0,
  input  wire   i_last0,
  input  word_t i_data1,
  input  wire   i_valid1,
  input  wire   i_last1,
  output int    o_errors
);

  word_t exp_q0 [$];
  word_t exp_q1 [$];
  int    beats [READER_NUM];
  int    errors = 0;
  string test_name = "reset";

  assign o_errors = errors;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic expect_word(input int k, input word_t w);
    if (k == 0) begin
      exp_q0.push_back(w);
    end else begin
      exp_q1.push_back(w);
    end
  endtask

  task automatic check_drained();
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      $display("Error in %s: words never returned (reader0 %0d, reader1 %0d)",
               test_name, exp_q0.size(), exp_q1.size());
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Per reader comparison
  ////////////////////////////////////////////////////////////////////

  task automatic check_beat(input int k, input word_t data, input logic valid,
                            input logic last);
    word_t exp;
    int    left;
    if (last && !valid) begin
      $display("Error in %s: reader%0d raised last without valid", test_name, k);
      errors++;
    end
    if (valid) begin
      left = (k == 0) ? exp_q0.size() : exp_q1.size();
      beats[k]++;
      if (left == 0) begin
        $display("Error in %s: reader%0d returned an extra word %h", test_name, k, data);
        errors++;
      end else begin
        if (k == 0) begin
          exp = exp_q0.pop_front();
        end else begin
          exp = exp_q1.pop_front();
        end
        if (data !== exp) begin
          $display("CHECK FAILED %s: reader%0d word %0d expected %h actual %h",
                   test_name, k, beats[k] - 1, exp, data);
          errors++;
        end
      end
      // Last belongs on the 16th word and nowhere else
      if (last && beats[k] != BURST_LEN) begin
        $display("CHECK FAILED %s: reader%0d last on word expected %0d actual %0d",
                 test_name, k, BURST_LEN, beats[k]);
        errors++;
      end
      if (!last && beats[k] == BURST_LEN) begin
        $display("CHECK FAILED %s: reader%0d last on word %0d expected 1 actual 0",
                 test_name, k, BURST_LEN);
        errors++;
      end
      if (last || beats[k] >= BURST_LEN) begin
        beats[k] = 0;
      end
    end
  endtask

  // Outputs are registered, so mid-cycle sampling sees settled values
  always @(negedge clk) begin
    if (rst_n) begin
      check_beat(0, i_data0, i_valid0, i_last0);
      check_beat(1, i_data1, i_valid1, i_last1);
    end
  end

endmodule

`default_nettype wire

// ==== tb/cp_s1_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_s1_asserts #(
  parameter bit HAS_VALID = 1'b1
) (
  input wire       clk,
  input wire       rst_n,
  input wire [1:0] i_req,
  input wire [1:0] i_gnt,
  input wire       i_valid
);

  ast_gnt_to_req: assert property (@(posedge clk) disable iff (!rst_n)
    ((i_gnt & ~i_req) == 2'b00))
    else $error("grant %b given without request %b", i_gnt, i_req);

  if (HAS_VALID) begin : g_reader
    // Fixed two cycle return, registered RAM then output register
    ast_valid_lag: assert property (@(posedge clk) disable iff (!rst_n)
      (i_valid == $past(|i_gnt, 2)))
      else $error("valid does not follow the grant by two cycles");
  end else begin : g_arbiter
    // At most one reader owns the read port per cycle
    ast_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(i_gnt))
      else $error("read grant is not one-hot or zero: %b", i_gnt);
  end

endmodule

bind cp_read_arbiter cp_s1_asserts #(.HAS_VALID(1'b0)) arbiter_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_req   (i_rd_req),
  .i_gnt   (o_rd_gnt),
  .i_valid (1'b0)
);

bind cp_burst_reader cp_s1_asserts #(.HAS_VALID(1'b1)) reader_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_req   ({1'b0, o_rd_req}),
  .i_gnt   ({1'b0, i_rd_gnt}),
  .i_valid (o_valid)
);

`default_nettype wire

// ==== source/cp_s1_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_s1_top
  import cp_mem_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  sample_t i_sample,
  input  wire     i_sample_vld,
  input  wire     i_start0,
  input  wire     i_start1,
  output word_t   o_data0,
  output logic    o_valid0,
  output logic    o_last0,
  output word_t   o_data1,
  output logic    o_valid1,
  output logic    o_last1
);

  logic                  wr_en;
  ram_addr_t             wr_addr;
  word_t                 wr_data;
  logic [READER_NUM-1:0] rd_req;
  logic [READER_NUM-1:0] rd_gnt;
  ram_addr_t             rd_addr0;
  ram_addr_t             rd_addr1;
  logic                  ram_rd_en;
  ram_addr_t             ram_rd_addr;
  word_t                 ram_rd_data;

  ////////////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////////////

  cp_sample_writer writer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_sample     (i_sample),
    .i_sample_vld (i_sample_vld),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data)
  );

  cp_sample_ram ram_i (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_en   (ram_rd_en),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (ram_rd_data)
  );

  ////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////

  cp_read_arbiter arbiter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_rd_req      (rd_req),
    .i_rd_addr0    (rd_addr0),
    .i_rd_addr1    (rd_addr1),
    .o_rd_gnt      (rd_gnt),
    .o_ram_rd_en   (ram_rd_en),
    .o_ram_rd_addr (ram_rd_addr)
  );

  cp_burst_reader #(
    .RD_BASE (RD_BASE0),
    .RD_STEP (RD_STEP0)
  ) reader0_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start0),
    .i_rd_gnt      (rd_gnt[0]),
    .i_ram_rd_data (ram_rd_data),
    .o_rd_req      (rd_req[0]),
    .o_rd_addr     (rd_addr0),
    .o_data        (o_data0),
    .o_valid       (o_valid0),
    .o_last        (o_last0)
  );

  cp_burst_reader #(
    .RD_BASE (RD_BASE1),
    .RD_STEP (RD_STEP1)
  ) reader1_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start1),
    .i_rd_gnt      (rd_gnt[1]),
    .i_ram_rd_data (ram_rd_data),
    .o_rd_req      (rd_req[1]),
    .o_rd_addr     (rd_addr1),
    .o_data        (o_data1),
    .o_valid       (o_valid1),
    .o_last        (o_last1)
  );

endmodule

`default_nettype wire

// ==== source/cp_burst_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_burst_reader
  import cp_mem_pkg::*;
  import cp_ctrl_pkg::*;
#(
  parameter ram_addr_t RD_BASE = RD_BASE0,
  parameter ram_addr_t RD_STEP = RD_STEP0
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       i_start,
  input  wire       i_rd_gnt,
  input  word_t     i_ram_rd_data,
  output logic      o_rd_req,
  output ram_addr_t o_rd_addr,
  output word_t     o_data,
  output logic      o_valid,
  output logic      o_last
);

  reader_state_t                state;
  logic                         start_d0;
  logic                         start_d1;
  logic                         start_d2;
  logic                         start_fall;
  logic [$clog2(BURST_LEN)-1:0] issue_cnt;
  logic                         gnt_take;
  logic                         last_issue;
  logic                         gnt_d1;
  logic                         last_d1;

  ////////////////////////////////////////////////////////////////////
  // Start synchronizer and falling edge
  ////////////////////////////////////////////////////////////////////

  // Two synchronizer stages then one flop for the previous level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_d0 <= 1'b0;
      start_d1 <= 1'b0;
      start_d2 <= 1'b0;
    end else begin
      start_d0 <= i_start;
      start_d1 <= start_d0;
      start_d2 <= start_d1;
    end
  end

  // Falling edge seen on the synchronized level
  assign start_fall = start_d2 & ~start_d1;

  ////////////////////////////////////////////////////////////////////
  // Burst FSM, issue counter and address
  ////////////////////////////////////////////////////////////////////

  assign o_rd_req   = (state == READ);
  assign gnt_take   = i_rd_gnt & o_rd_req;
  assign last_issue = gnt_take && (issue_cnt == BURST_LEN - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      issue_cnt <= '0;
      o_rd_addr <= RD_BASE;
    end else begin
      unique case (state)
        IDLE: begin
          // Only an idle reader reacts to a start edge
          if (start_fall) begin
            state     <= READ;
            issue_cnt <= '0;
          end
        end
        READ: begin
          if (gnt_take) begin
            issue_cnt <= issue_cnt + 1'b1;
            o_rd_addr <= o_rd_addr + RD_STEP;
          end
          if (last_issue) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          // Final word leaves the RAM this cycle
          if (gnt_d1 && last_d1) begin
            state     <= IDLE;
            o_rd_addr <= RD_BASE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Return pipeline
  ////////////////////////////////////////////////////////////////////

  // Stage one waits for the registered RAM read, stage two owns the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_d1  <= 1'b0;
      last_d1 <= 1'b0;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      gnt_d1  <= gnt_take;
      last_d1 <= last_issue;
      o_valid <= gnt_d1;
      o_last  <= gnt_d1 & last_d1;
    end
  end

  // Read data is broadcast, keep only our own slot
  always_ff @(posedge clk) begin
    if (gnt_d1) begin
      o_data <= i_ram_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/cp_read_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_read_arbiter
  import cp_mem_pkg::*;
  import cp_ctrl_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [READER_NUM-1:0]   i_rd_req,
  input  ram_addr_t              i_rd_addr0,
  input  ram_addr_t              i_rd_addr1,
  output logic [READER_NUM-1:0]  o_rd_gnt,
  output logic                   o_ram_rd_en,
  output ram_addr_t              o_ram_rd_addr
);

  rr_ptr_t rr_ptr;
  logic    contested;

  assign contested = &i_rd_req;

  ////////////////////////////////////////////////////////////////////
  // Grant decision
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    o_rd_gnt = '0;
    if (contested) begin
      // Both asking, pointer picks the winner
      o_rd_gnt[rr_ptr] = 1'b1;
    end else begin
      // Lone requester gets the port every cycle
      o_rd_gnt = i_rd_req;
    end
  end

  // Pointer moves only when someone actually had to wait
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= 1'b0;
    end else if (contested) begin
      rr_ptr <= ~rr_ptr;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // RAM read port
  ////////////////////////////////////////////////////////////////////

  assign o_ram_rd_en = |o_rd_gnt;

  always_comb begin
    if (o_rd_gnt[1]) begin
      o_ram_rd_addr = i_rd_addr1;
    end else begin
      o_ram_rd_addr = i_rd_addr0;
    end
  end

endmodule

`default_nettype wire

// ==== source/cp_sample_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_sample_writer
  import cp_mem_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  sample_t   i_sample,
  input  wire       i_sample_vld,
  output logic      o_wr_en,
  output ram_addr_t o_wr_addr,
  output word_t     o_wr_data
);

  logic [$clog2(SAMPLES_PER_WORD)-1:0] lane;
  word_t                               pack;
  logic                                word_done;

  // Fourth sample of a group closes the word
  assign word_done = i_sample_vld && (lane == SAMPLES_PER_WORD - 1);

  ////////////////////////////////////////////////////////////////////
  // Packing register
  ////////////////////////////////////////////////////////////////////

  // New samples enter at the top, so the first one ends in the low lane
  always_ff @(posedge clk) begin
    if (i_sample_vld) begin
      pack <= {i_sample, pack[$bits(word_t)-1:SAMPLE_W]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane <= '0;
    end else if (i_sample_vld) begin
      lane <= lane + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Write strobe and address
  ////////////////////////////////////////////////////////////////////

  // Write goes out the cycle after the group is complete
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= word_done;
    end
  end

  // Address advances after each write and wraps with the RAM depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_addr <= '0;
    end else if (o_wr_en) begin
      o_wr_addr <= o_wr_addr + 1'b1;
    end
  end

  assign o_wr_data = pack;

endmodule

`default_nettype wire

// ==== source/cp_sample_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp_sample_ram
  import cp_mem_pkg::*;
(
  input  wire       clk,
  input  wire       i_wr_en,
  input  ram_addr_t i_wr_addr,
  input  word_t     i_wr_data,
  input  wire       i_rd_en,
  input  ram_addr_t i_rd_addr,
  output word_t     o_rd_data
);

  word_t mem [RAM_DEPTH];

  ////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////

  // Registered read, old contents on a same-address write
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== source/cp_ctrl_pkg.sv ====
`default_nettype none

package cp_ctrl_pkg;

  // Burst reader FSM
  typedef enum logic [1:0] {
    IDLE,
    READ,
    DRAIN
  } reader_state_t;

  // Round-robin pointer, 0 favours reader 0
  typedef logic rr_ptr_t;

endpackage

`default_nettype wire

// ==== source/cp_mem_pkg.sv ====
`default_nettype none

package cp_mem_pkg;

  ////////////////////////////////////////////////////////////////////
  // RAM geometry and sample packing
  ////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W         = 32;
  localparam int SAMPLES_PER_WORD = 4;
  localparam int RAM_DEPTH        = 64;

  // One ADC sample
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Four samples per word, sample 0 in the low bits
  typedef logic [SAMPLES_PER_WORD*SAMPLE_W-1:0] word_t;

  // Word address into the sample RAM
  typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;

  ////////////////////////////////////////////////////////////////////
  // Burst readers on the shared read port
  ////////////////////////////////////////////////////////////////////

  localparam int BURST_LEN  = 16;
  localparam int READER_NUM = 2;

  // Reader 0 walks the lower half word by word
  localparam ram_addr_t RD_BASE0 = 6'd0;
  localparam ram_addr_t RD_STEP0 = 6'd1;

  // Reader 1 takes every other word of the upper half
  localparam ram_addr_t RD_BASE1 = 6'd32;
  localparam ram_addr_t RD_STEP1 = 6'd2;

endpackage

`default_nettype wire
